// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps
TOP       ?= lbp_tb
FILELIST  ?= lbp_desc.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard bench/*.svh)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a listed source, a header or the list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: bench/lbp_model.svh
`ifndef LBP_MODEL_SVH
`define LBP_MODEL_SVH

// row offset of neighbor k, counter-clockwise from east
function automatic int nbr_row(input int k);
  case (k)
    1, 2, 3: return -1;
    5, 6, 7: return 1;
    default: return 0;
  endcase
endfunction

// column offset of neighbor k
function automatic int nbr_col(input int k);
  case (k)
    0, 1, 7: return 1;
    3, 4, 5: return -1;
    default: return 0;
  endcase
endfunction

// uniform rings keep their count of ones, others get 9
function automatic lbp_pkg::code_t riu2_code(input lbp_pkg::pattern_t p);
  int changes;
  int ones;
  changes = 0;
  ones = 0;
  for (int k = 0; k < 8; k++) begin
    if (p[k]) ones++;
    // compare with the previous neighbor on the ring
    if (p[k] != p[(k + 7) % 8]) changes++;
  end
  if (changes > 2) return 4'd9;
  return lbp_pkg::code_t'(ones);
endfunction

// expected codes for center (r,c) of frame f
function automatic lbp_pkg::result_t model_result(input int f, input int r, input int c);
  int sum;
  int nb;
  lbp_pkg::pattern_t ni;
  lbp_pkg::pattern_t cd;
  lbp_pkg::result_t res;
  sum = 0;
  for (int dr = -1; dr <= 1; dr++) begin
    for (int dc = -1; dc <= 1; dc++) begin
      sum += frame_pix[f][r + dr][c + dc];
    end
  end
  for (int k = 0; k < 8; k++) begin
    nb = frame_pix[f][r + nbr_row(k)][c + nbr_col(k)];
    // neighbor against the patch mean, scaled by nine
    ni[k] = (9 * nb >= sum);
    cd[k] = (nb >= frame_pix[f][r][c]);
  end
  res.ni_code = riu2_code(ni);
  res.cd_code = riu2_code(cd);
  return res;
endfunction

`endif

// File: bench/lbp_tb.sv
`default_nettype none

module lbp_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int COLS = 16;
  localparam int ROWS = 12;
  localparam int FIFO_DEPTH = 8;
  localparam int NUM_FRAMES = 5;
  localparam int FLAT_FRAME = 3;
  localparam int CHECKER_FRAME = 4;
  localparam int FLAT_VALUE = 97;
  localparam int CHECK_HI = 200;
  localparam int CHECK_LO = 40;
  localparam int PER_FRAME = (ROWS - 2) * (COLS - 2);
  localparam int TOTAL_RES = NUM_FRAMES * PER_FRAME;
  localparam int TOTAL_PIX = NUM_FRAMES * ROWS * COLS;
  localparam int MAX_OUT = 12;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * COLS * ROWS * 20;

  logic             clk;
  logic             rst_i;
  logic             pix_valid_i;
  lbp_pkg::pixel_t  pix_i;
  logic             pix_credit_o;
  logic             res_credit_i;
  logic             res_valid_o;
  lbp_pkg::result_t res_o;
  logic             frame_done_o;

  int frame_pix [NUM_FRAMES][ROWS][COLS];
  int seed;
  int sink_seed;
  int pix_sent;
  int credit_pulses;
  int granted;
  int received;

  `include "lbp_model.svh"

  lbp_top #(
      .COLS(COLS),
      .ROWS(ROWS),
      .FIFO_DEPTH(FIFO_DEPTH)
  ) dut (
      .clk(clk),
      .rst_i(rst_i),
      .pix_valid_i(pix_valid_i),
      .pix_i(pix_i),
      .pix_credit_o(pix_credit_o),
      .res_credit_i(res_credit_i),
      .res_valid_o(res_valid_o),
      .res_o(res_o),
      .frame_done_o(frame_done_o)
  );

  always #4 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "check %s failed", name);
    end
  endtask

  // three random frames, then a flat one and a checkerboard
  task automatic build_frames();
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          if (f == FLAT_FRAME) begin
            frame_pix[f][r][c] = FLAT_VALUE;
          end else if (f == CHECKER_FRAME) begin
            frame_pix[f][r][c] = ((r + c) % 2 == 1) ? CHECK_HI : CHECK_LO;
          end else if (f == 1) begin
            // few levels, so many compares tie
            frame_pix[f][r][c] = ($random(seed) & 3) * 60;
          end else begin
            frame_pix[f][r][c] = $random(seed) & 255;
          end
        end
      end
    end
  endtask

  function automatic int pixel_at(input int p);
    int f;
    int rem;
    f = p / (ROWS * COLS);
    rem = p % (ROWS * COLS);
    return frame_pix[f][rem / COLS][rem % COLS];
  endfunction

  // credited source with random gaps
  task automatic drive_pixels();
    int p;
    p = 0;
    while (p < TOTAL_PIX) begin
      @(posedge clk);
      if ((FIFO_DEPTH - p + credit_pulses) > 0 && ($random(seed) & 3) != 0) begin
        pix_valid_i <= 1'b1;
        pix_i <= lbp_pkg::pixel_t'(pixel_at(p));
        pix_sent <= p + 1;
        p++;
      end else begin
        pix_valid_i <= 1'b0;
      end
    end
    @(posedge clk);
    pix_valid_i <= 1'b0;
  endtask

  // sink starts starved so the pipeline and the queue fill up
  task automatic drive_credits();
    int starve;
    starve = 40;
    forever begin
      @(posedge clk);
      if (starve > 0) begin
        starve--;
        res_credit_i <= 1'b0;
      end else if (($random(sink_seed) & 63) == 0) begin
        starve = 20 + ($random(sink_seed) & 63);
        res_credit_i <= 1'b0;
      end else if (granted - received < MAX_OUT && ($random(sink_seed) & 1) == 1) begin
        res_credit_i <= 1'b1;
        granted <= granted + 1;
      end else begin
        res_credit_i <= 1'b0;
      end
    end
  endtask

  // input credits never outnumber pixels sent
  always @(posedge clk) begin
    if (!rst_i && pix_credit_o) begin
      check_val("input credit pulse", 32'd1, 32'(credit_pulses < pix_sent));
      credit_pulses <= credit_pulses + 1;
    end
  end

  always @(posedge clk) begin : result_monitor
    lbp_pkg::result_t want;
    int f;
    int idx;
    int r;
    int c;
    if (!rst_i && res_valid_o) begin
      if (received >= TOTAL_RES) begin
        $display("a result arrived after all frames were complete");
        $display("Finished with errors");
        $fatal(1, "extra result");
      end
      f = received / PER_FRAME;
      idx = received % PER_FRAME;
      r = 1 + idx / (COLS - 2);
      c = 1 + idx % (COLS - 2);
      want = model_result(f, r, c);
      check_val("output credit held", 32'd1, 32'(granted - received > 0));
      check_val($sformatf("frame %0d (%0d,%0d) ni_code", f, r, c),
                32'(want.ni_code), 32'(res_o.ni_code));
      check_val($sformatf("frame %0d (%0d,%0d) cd_code", f, r, c),
                32'(want.cd_code), 32'(res_o.cd_code));
      check_val($sformatf("frame %0d (%0d,%0d) frame_done", f, r, c),
                32'(idx == PER_FRAME - 1), 32'(frame_done_o));
      if (f == FLAT_FRAME) begin
        check_val("flat frame ni_code", 32'd8, 32'(res_o.ni_code));
        check_val("flat frame cd_code", 32'd8, 32'(res_o.cd_code));
      end
      // bright centers see only darker or equal neighbors
      if (f == CHECKER_FRAME && frame_pix[f][r][c] == CHECK_HI) begin
        check_val("checkerboard cd_code", 32'd9, 32'(res_o.cd_code));
      end
      received <= received + 1;
    end else if (!rst_i) begin
      check_val("frame_done without result", 32'd0, 32'(frame_done_o));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: only %0d of %0d results after %0d cycles",
             received, TOTAL_RES, WATCHDOG_CYCLES);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    pix_valid_i = 1'b0;
    pix_i = '0;
    res_credit_i = 1'b0;
    seed = 6829;
    pix_sent = 0;
    credit_pulses = 0;
    granted = 0;
    received = 0;
    build_frames();
    sink_seed = $random(seed);
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    fork
      drive_pixels();
      drive_credits();
    join_none
    while (received < TOTAL_RES) begin
      @(posedge clk);
    end
    // idle tail lets a stray result reach the monitor
    repeat (60) @(posedge clk);
    check_val("input credits returned", 32'(TOTAL_PIX), 32'(credit_pulses));
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/credit_tx.sv
`default_nettype none

module credit_tx #(
    parameter int CNT_W = 4
) (
    input  wire               clk,
    input  wire               rst_i,
    input  wire               credit_i,
    input  wire               valid_i,
    input  wire               last_i,
    input  lbp_pkg::result_t  res_i,
    output logic              adv_o,
    output logic              res_valid_o,
    output lbp_pkg::result_t  res_o,
    output logic              frame_done_o
);
  logic [CNT_W-1:0] credits;
  logic             send;

  // whole pipeline moves only while the sink has room
  assign adv_o = (credits != '0);
  assign send  = valid_i & adv_o;

  always_ff @(posedge clk) begin
    if (send) begin
      res_o <= res_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      credits      <= '0;
      res_valid_o  <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      res_valid_o  <= send;
      frame_done_o <= send & last_i;
      case ({credit_i, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/lbp_bits.sv
`default_nettype none

module lbp_bits (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     adv_i,
    input  lbp_pkg::window_t        win_i,
    input  wire                     valid_i,
    input  wire                     last_i,
    output lbp_pkg::pattern_pair_t  pat_o,
    output logic                    valid_o,
    output logic                    last_o
);
  lbp_pkg::pixel_t        nb [8];
  logic [11:0]            patch_sum;
  lbp_pkg::pattern_pair_t pat_d;

  // neighbor k in pattern bit order
  assign nb = '{win_i.e, win_i.ne, win_i.n, win_i.nw, win_i.w, win_i.sw, win_i.s, win_i.se};

  always_comb begin
    patch_sum = 12'(win_i.center);
    for (int k = 0; k < 8; k++) begin
      patch_sum = patch_sum + 12'(nb[k]);
    end
    for (int k = 0; k < 8; k++) begin
      // 9*nb against the sum instead of nb against the mean
      pat_d.ni[k] = ({1'b0, nb[k], 3'b000} + 12'(nb[k])) >= patch_sum;
      pat_d.cd[k] = nb[k] >= win_i.center;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      pat_o <= pat_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      last_o  <= 1'b0;
    end else if (adv_i) begin
      valid_o <= valid_i;
      last_o  <= last_i;
    end
  end

endmodule

`default_nettype wire

// File: design/lbp_pkg.sv
`default_nettype none

package lbp_pkg;

  // one gray sample
  typedef logic [7:0] pixel_t;

  // 3x3 patch, neighbors counter-clockwise from east
  typedef struct packed {
    pixel_t center;
    pixel_t e;
    pixel_t ne;
    pixel_t n;
    pixel_t nw;
    pixel_t w;
    pixel_t sw;
    pixel_t s;
    pixel_t se;
  } window_t;

  // bit 0 is east, bit 7 is south-east
  typedef logic [7:0] pattern_t;

  typedef struct packed {
    pattern_t ni;
    pattern_t cd;
  } pattern_pair_t;

  // riu2 code, 0 to 9
  typedef logic [3:0] code_t;

  // output word
  typedef struct packed {
    code_t ni_code;
    code_t cd_code;
  } result_t;

  // frame sequencing in the line buffer
  typedef enum logic [1:0] {
    st_fill,
    st_run,
    st_flush
  } seq_state_t;

endpackage

`default_nettype wire

// File: design/lbp_top.sv
`default_nettype none

module lbp_top #(
    parameter int COLS       = 16,
    parameter int ROWS       = 12,
    parameter int FIFO_DEPTH = 8,
    parameter int CNT_W      = 4
) (
    input  wire               clk,
    input  wire               rst_i,
    input  wire               pix_valid_i,
    input  lbp_pkg::pixel_t   pix_i,
    output logic              pix_credit_o,
    input  wire               res_credit_i,
    output logic              res_valid_o,
    output lbp_pkg::result_t  res_o,
    output logic              frame_done_o
);
  logic                   adv;
  lbp_pkg::pixel_t        fifo_data;
  logic                   fifo_not_empty;
  lbp_pkg::window_t       win;
  logic                   win_valid;
  logic                   win_last;
  lbp_pkg::pattern_pair_t pat;
  logic                   pat_valid;
  logic                   pat_last;
  lbp_pkg::result_t       codes;
  logic                   codes_valid;
  logic                   codes_last;

  // head of queue is popped on every advancing cycle
  pix_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
  ) u_pix_fifo (
      .clk(clk),
      .rst_i(rst_i),
      .push_i(pix_valid_i),
      .data_i(pix_i),
      .pop_i(adv),
      .data_o(fifo_data),
      .not_empty_o(fifo_not_empty),
      .credit_o(pix_credit_o)
  );

  line_buffer #(
      .COLS(COLS),
      .ROWS(ROWS)
  ) u_line_buffer (
      .clk(clk),
      .rst_i(rst_i),
      .adv_i(adv),
      .pix_valid_i(fifo_not_empty),
      .pix_i(fifo_data),
      .win_o(win),
      .win_valid_o(win_valid),
      .last_o(win_last)
  );

  lbp_bits u_lbp_bits (
      .clk(clk),
      .rst_i(rst_i),
      .adv_i(adv),
      .win_i(win),
      .valid_i(win_valid),
      .last_i(win_last),
      .pat_o(pat),
      .valid_o(pat_valid),
      .last_o(pat_last)
  );

  riu2_map u_riu2_map (
      .clk(clk),
      .rst_i(rst_i),
      .adv_i(adv),
      .pat_i(pat),
      .valid_i(pat_valid),
      .last_i(pat_last),
      .res_o(codes),
      .valid_o(codes_valid),
      .last_o(codes_last)
  );

  credit_tx #(
      .CNT_W(CNT_W)
  ) u_credit_tx (
      .clk(clk),
      .rst_i(rst_i),
      .credit_i(res_credit_i),
      .valid_i(codes_valid),
      .last_i(codes_last),
      .res_i(codes),
      .adv_o(adv),
      .res_valid_o(res_valid_o),
      .res_o(res_o),
      .frame_done_o(frame_done_o)
  );

endmodule

`default_nettype wire

// File: design/line_buffer.sv
`default_nettype none

module line_buffer #(
    parameter int COLS = 16,
    parameter int ROWS = 12
) (
    input  wire               clk,
    input  wire               rst_i,
    input  wire               adv_i,
    input  wire               pix_valid_i,
    input  lbp_pkg::pixel_t   pix_i,
    output lbp_pkg::window_t  win_o,
    output logic              win_valid_o,
    output logic              last_o
);
  localparam int COL_W = $clog2(COLS);
  localparam int ROW_W = $clog2(ROWS + 1);

  // row r-1 and row r-2 at the current column
  lbp_pkg::pixel_t line1 [COLS];
  lbp_pkg::pixel_t line2 [COLS];

  logic [COL_W-1:0]    col;
  logic [ROW_W-1:0]    row;
  lbp_pkg::seq_state_t state;
  logic                take;
  logic                interior;
  logic                frame_end;

  assign take      = adv_i & pix_valid_i;
  // centers sit one row up and one column left of the incoming pixel
  assign interior  = (state == lbp_pkg::st_run) && (col >= COL_W'(2));
  assign frame_end = (row == ROW_W'(ROWS - 1)) && (col == COL_W'(COLS - 1));

  // row memories and window shift
  always_ff @(posedge clk) begin
    if (take) begin
      line2[col] <= line1[col];
      line1[col] <= pix_i;
      win_o.nw     <= win_o.n;
      win_o.n      <= win_o.ne;
      win_o.ne     <= line2[col];
      win_o.w      <= win_o.center;
      win_o.center <= win_o.e;
      win_o.e      <= line1[col];
      win_o.sw     <= win_o.s;
      win_o.s      <= win_o.se;
      win_o.se     <= pix_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      col         <= '0;
      row         <= '0;
      state       <= lbp_pkg::st_fill;
      win_valid_o <= 1'b0;
      last_o      <= 1'b0;
    end else if (adv_i) begin
      win_valid_o <= take & interior;
      last_o      <= take & interior & frame_end;
      if (take) begin
        if (col == COL_W'(COLS - 1)) begin
          col <= '0;
          row <= row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
      case (state)
        lbp_pkg::st_fill: begin
          // two full rows stored
          if (take && row == ROW_W'(1) && col == COL_W'(COLS - 1)) begin
            state <= lbp_pkg::st_run;
          end
        end
        lbp_pkg::st_run: begin
          if (take && frame_end) begin
            state <= lbp_pkg::st_flush;
          end
        end
        default: begin
          // next frame counts rows from zero again
          row   <= '0;
          state <= lbp_pkg::st_fill;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/pix_fifo.sv
`default_nettype none

module pix_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire              clk,
    input  wire              rst_i,
    input  wire              push_i,
    input  lbp_pkg::pixel_t  data_i,
    input  wire              pop_i,
    output lbp_pkg::pixel_t  data_o,
    output logic             not_empty_o,
    output logic             credit_o
);
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  lbp_pkg::pixel_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // pop only when something is queued
  assign pop         = pop_i & not_empty_o;
  assign not_empty_o = (count != '0);
  assign data_o      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      // freed slot goes back to the source next cycle
      credit_o <= pop;
      if (push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/riu2_map.sv
`default_nettype none

module riu2_map (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     adv_i,
    input  lbp_pkg::pattern_pair_t  pat_i,
    input  wire                     valid_i,
    input  wire                     last_i,
    output lbp_pkg::result_t        res_o,
    output logic                    valid_o,
    output logic                    last_o
);
  // uniform patterns map to their popcount, the rest to 9
  function automatic lbp_pkg::code_t riu2(input lbp_pkg::pattern_t p);
    logic [3:0] trans;
    logic [3:0] ones;
    trans = '0;
    ones  = '0;
    for (int k = 0; k < 8; k++) begin
      // bit 7 wraps around to bit 0
      trans = trans + 4'(p[k] ^ p[(k + 1) % 8]);
      ones  = ones + 4'(p[k]);
    end
    return (trans <= 4'd2) ? ones : 4'd9;
  endfunction

  always_ff @(posedge clk) begin
    if (adv_i) begin
      res_o.ni_code <= riu2(pat_i.ni);
      res_o.cd_code <= riu2(pat_i.cd);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      last_o  <= 1'b0;
    end else if (adv_i) begin
      valid_o <= valid_i;
      last_o  <= last_i;
    end
  end

endmodule

`default_nettype wire

// File: lbp_desc.f
+incdir+bench
design/lbp_pkg.sv
design/pix_fifo.sv
design/line_buffer.sv
design/lbp_bits.sv
design/riu2_map.sv
design/credit_tx.sv
design/lbp_top.sv
bench/lbp_tb.sv
